// ==== hw/pipe_core_config.svh ====
`ifndef PIPE_CORE_CONFIG_SVH
`define PIPE_CORE_CONFIG_SVH

// datapath sizing for pipe_core

// register and result word
`define PC_DATA_W 16

// architectural registers, r0 hardwired to zero
`define PC_NREGS 8

// bits to name one register
`define PC_IDX_W 3

// immediate field of the I format, sign-extended on use
`define PC_IMM_W 6

`endif

// ==== hw/pipe_core_pkg.sv ====
`include "pipe_core_config.svh"

package pipe_core_pkg;

    //////////////////////////////////////////////////////////////////////
    // opcodes
    //////////////////////////////////////////////////////////////////////

    localparam int OP_W = 4;                      // opcode field width

    localparam logic [OP_W-1:0] OP_NOP  = 4'd0;
    localparam logic [OP_W-1:0] OP_ADD  = 4'd1;   // rd = rs1 + rs2
    localparam logic [OP_W-1:0] OP_SUB  = 4'd2;   // rd = rs1 - rs2
    localparam logic [OP_W-1:0] OP_AND  = 4'd3;
    localparam logic [OP_W-1:0] OP_XOR  = 4'd4;
    localparam logic [OP_W-1:0] OP_ADDI = 4'd5;   // rd = rs1 + sext(imm)
    localparam logic [OP_W-1:0] OP_OUT  = 4'd6;   // emit rs1 on result port
    // 7..15 fall through as nop

    //////////////////////////////////////////////////////////////////////
    // instruction formats
    //////////////////////////////////////////////////////////////////////

    // register form
    typedef struct packed {
        logic [OP_W-1:0]                               op;
        logic [`PC_IDX_W-1:0]                          rd;
        logic [`PC_IDX_W-1:0]                          rs1;
        logic [`PC_IDX_W-1:0]                          rs2;
        logic [`PC_DATA_W-OP_W-3*`PC_IDX_W-1:0]        unused;  // pad to 16
    } instr_r_t;

    // immediate form, imm overlays rs2 and the pad bits
    typedef struct packed {
        logic [OP_W-1:0]      op;
        logic [`PC_IDX_W-1:0] rd;
        logic [`PC_IDX_W-1:0] rs1;
        logic [`PC_IMM_W-1:0] imm;
    } instr_i_t;

    // one 16-bit word, two decodes picked by op
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

// ==== hw/pipe_ctl_if.sv ====
`include "pipe_core_config.svh"

// hazard controller <-> one stage register
interface pipe_ctl_if;

    logic                 advance;   // take upstream word this edge
    logic                 bubble;    // drop to a nop this edge
    logic                 occupied;  // stage holds a live instruction
    logic                 writes;    // live instruction writes rd
    logic [`PC_IDX_W-1:0] dest;      // its rd

    // controller side
    modport ctl (
        output advance,
        output bubble,
        input  occupied,
        input  writes,
        input  dest
    );

    // stage side
    modport stage (
        input  advance,
        input  bubble,
        output occupied,
        output writes,
        output dest
    );

endinterface

// ==== hw/stage_reg.sv ====
`include "pipe_core_config.svh"

// one pipeline stage: hold, load or bubble
module stage_reg #(
    parameter int WIDTH = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [WIDTH-1:0]     d,
    output logic [WIDTH-1:0]     q,
    input  logic                 d_writes,
    input  logic [`PC_IDX_W-1:0] d_dest,
    pipe_ctl_if.stage            ctl
);

    logic                 occ_q;   // live word flag
    logic                 wr_q;    // word writes a register
    logic [`PC_IDX_W-1:0] dest_q;  // destination of that write

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            q      <= '0;
            occ_q  <= 1'b0;
            wr_q   <= 1'b0;
            dest_q <= '0;
        end
        else if (ctl.bubble)              // bubble wins over load
        begin
            q      <= '0;                 // all-zero word decodes as nop
            occ_q  <= 1'b0;
            wr_q   <= 1'b0;
            dest_q <= '0;
        end
        else if (ctl.advance)
        begin
            q      <= d;
            occ_q  <= 1'b1;               // controller only loads live words
            wr_q   <= d_writes;
            dest_q <= d_dest;
        end
        // neither: hold everything
    end

    // status back to the controller
    assign ctl.occupied = occ_q;
    assign ctl.writes   = wr_q;
    assign ctl.dest     = dest_q;

endmodule

// ==== hw/reg_file.sv ====
`include "pipe_core_config.svh"

// 8 x 16 register file, 2 read ports, 1 write port
module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`PC_IDX_W-1:0]  ra_idx,
    input  logic [`PC_IDX_W-1:0]  rb_idx,
    output logic [`PC_DATA_W-1:0] ra_data,
    output logic [`PC_DATA_W-1:0] rb_data,
    input  logic                  we,
    input  logic [`PC_IDX_W-1:0]  wr_idx,
    input  logic [`PC_DATA_W-1:0] wr_data
);

    logic [`PC_DATA_W-1:0] regs [`PC_NREGS];

    // read with r0 forced low and same-cycle write forwarded
    function automatic logic [`PC_DATA_W-1:0] rd_port(input logic [`PC_IDX_W-1:0] idx);
        if (idx == '0)
            return '0;
        else if (we && (wr_idx == idx))
            return wr_data;               // bypass, s2 result not yet in the array
        else
            return regs[idx];
    endfunction

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `PC_NREGS; i++)
            begin
                regs[i] <= '0;            // architectural state starts at zero
            end
        end
        else if (we && (wr_idx != '0))    // r0 writes dropped
        begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign ra_data = rd_port(ra_idx);
    assign rb_data = rd_port(rb_idx);

endmodule

// ==== hw/hazard_ctl.sv ====
`include "pipe_core_config.svh"

// pipeline control: start-up, RAW stall, result back-pressure
module hazard_ctl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`PC_IDX_W-1:0] s0_rs1,
    input  logic [`PC_IDX_W-1:0] s0_rs2,
    input  logic                 s0_uses_rs2,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic                 s2_is_out,
    output logic                 res_valid,
    input  logic                 res_ready,
    pipe_ctl_if.ctl              c0,
    pipe_ctl_if.ctl              c1,
    pipe_ctl_if.ctl              c2
);

    logic started_q;   // low for the first cycle out of reset
    logic freeze;      // whole pipe holds
    logic raw_hit;     // s0 reads what s1 is about to write
    logic s1_hit;      // index match against s1 rd

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            started_q <= 1'b0;
        else
            started_q <= 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // result port and freeze
    //////////////////////////////////////////////////////////////////////

    assign res_valid = c2.occupied && s2_is_out;
    assign freeze    = res_valid && !res_ready;   // out stuck in s2

    //////////////////////////////////////////////////////////////////////
    // read-after-write against s1
    //////////////////////////////////////////////////////////////////////

    // s2 hazards are covered by the register file bypass
    assign s1_hit  = (c1.dest == s0_rs1) || (s0_uses_rs2 && (c1.dest == s0_rs2));
    assign raw_hit = c0.occupied && c1.occupied && c1.writes && s1_hit;

    assign in_ready = started_q && !freeze && !raw_hit;

    //////////////////////////////////////////////////////////////////////
    // per-stage advance / bubble
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // s0: load a new word, or empty out once its word moved on
        c0.advance = in_ready && in_valid;
        c0.bubble  = in_ready && !in_valid;

        // s1: take s0 unless stalled, nop in the gap
        c1.advance = !freeze && !raw_hit && c0.occupied;
        c1.bubble  = !freeze && (raw_hit || !c0.occupied);

        // s2: always drains unless frozen
        c2.advance = !freeze && c1.occupied;
        c2.bubble  = !freeze && !c1.occupied;
    end

endmodule

// ==== hw/exec_unit.sv ====
`include "pipe_core_config.svh"

// execute stage: format select + ALU
module exec_unit (
    input  pipe_core_pkg::instr_u  instr,
    input  logic [`PC_DATA_W-1:0]  opa,
    input  logic [`PC_DATA_W-1:0]  opb,
    output logic [`PC_DATA_W-1:0]  result,
    output logic                   writes
);

    import pipe_core_pkg::*;

    instr_r_t              rv;        // register view
    instr_i_t              iv;        // immediate view
    logic                  is_imm;
    logic [`PC_DATA_W-1:0] imm_ext;
    logic [`PC_DATA_W-1:0] opb_sel;   // second ALU input
    logic [`PC_IDX_W-1:0]  rd_sel;
    logic                  op_wr;     // opcode class writes rd

    assign rv     = instr.r;
    assign iv     = instr.i;
    assign is_imm = (iv.op == OP_ADDI);

    // sign-extend the 6-bit immediate
    assign imm_ext = {{(`PC_DATA_W-`PC_IMM_W){iv.imm[`PC_IMM_W-1]}}, iv.imm};

    assign opb_sel = is_imm ? imm_ext : opb;
    assign rd_sel  = rv.rd;                    // same bit slot in both views

    always_comb
    begin
        result = '0;
        op_wr  = 1'b0;
        case (rv.op)
            OP_ADD, OP_ADDI:
            begin
                result = opa + opb_sel;
                op_wr  = 1'b1;
            end
            OP_SUB:
            begin
                result = opa - opb_sel;
                op_wr  = 1'b1;
            end
            OP_AND:
            begin
                result = opa & opb_sel;
                op_wr  = 1'b1;
            end
            OP_XOR:
            begin
                result = opa ^ opb_sel;
                op_wr  = 1'b1;
            end
            OP_OUT:
                result = opa;             // rs1 goes out unchanged
            default:
                result = '0;              // nop and unknown ops
        endcase
    end

    // rd = 0 never counts as a write
    assign writes = op_wr && (rd_sel != '0);

endmodule

// ==== hw/pipe_core_top.sv ====
`include "pipe_core_config.svh"

// three-stage in-order core: s0 fetch latch, s1 operands, s2 execute/wb
module pipe_core_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic [`PC_DATA_W-1:0] in_instr,
    output logic                  res_valid,
    input  logic                  res_ready,
    output logic [`PC_DATA_W-1:0] res_data
);

    import pipe_core_pkg::*;

    localparam int INSTR_W = $bits(instr_u);
    localparam int S1_W    = INSTR_W + 2 * `PC_DATA_W;            // instr, opa, opb
    localparam int S2_W    = OP_W + `PC_IDX_W + `PC_DATA_W;       // op, rd, result

    // input decode
    instr_u                in_u;
    logic                  in_writes;     // incoming word writes rd

    // s0
    logic [INSTR_W-1:0]    s0_q;
    instr_u                s0_instr;
    instr_r_t              s0_r;
    instr_i_t              s0_i;
    logic                  s0_uses_rs2;
    logic [`PC_DATA_W-1:0] rf_a;
    logic [`PC_DATA_W-1:0] rf_b;

    // s1
    logic [S1_W-1:0]       s1_d;
    logic [S1_W-1:0]       s1_q;
    instr_u                s1_instr;
    logic [`PC_DATA_W-1:0] s1_opa;
    logic [`PC_DATA_W-1:0] s1_opb;
    logic [`PC_DATA_W-1:0] ex_result;
    logic                  ex_writes;

    // s2
    logic [S2_W-1:0]       s2_d;
    logic [S2_W-1:0]       s2_q;
    logic [OP_W-1:0]       s2_op;
    logic [`PC_IDX_W-1:0]  s2_rd;
    logic [`PC_DATA_W-1:0] s2_result;
    logic                  s2_is_out;

    pipe_ctl_if c0 ();
    pipe_ctl_if c1 ();
    pipe_ctl_if c2 ();

    //////////////////////////////////////////////////////////////////////
    // s0: fetch latch
    //////////////////////////////////////////////////////////////////////

    assign in_u      = in_instr;
    assign in_writes = (in_u.i.op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI})
                       && (in_u.i.rd != '0);

    stage_reg #(.WIDTH(INSTR_W)) s0_reg (
        .clk(clk), .rst_n(rst_n), .d(in_instr), .q(s0_q),
        .d_writes(in_writes), .d_dest(in_u.i.rd), .ctl(c0.stage)
    );

    assign s0_instr    = s0_q;
    assign s0_r        = s0_instr.r;
    assign s0_i        = s0_instr.i;
    assign s0_uses_rs2 = s0_r.op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR};  // R-form ALU

    // operands read on the way into s1, rs1 sits at the same slot in both views
    reg_file rf_i (
        .clk(clk), .rst_n(rst_n),
        .ra_idx(s0_i.rs1), .rb_idx(s0_r.rs2), .ra_data(rf_a), .rb_data(rf_b),
        .we(c2.writes), .wr_idx(s2_rd), .wr_data(s2_result)
    );

    //////////////////////////////////////////////////////////////////////
    // s1: operands, s2: result
    //////////////////////////////////////////////////////////////////////

    assign s1_d = {s0_q, rf_a, rf_b};

    stage_reg #(.WIDTH(S1_W)) s1_reg (
        .clk(clk), .rst_n(rst_n), .d(s1_d), .q(s1_q),
        .d_writes(c0.writes), .d_dest(c0.dest), .ctl(c1.stage)
    );

    assign {s1_instr, s1_opa, s1_opb} = s1_q;

    exec_unit ex_i (
        .instr(s1_instr), .opa(s1_opa), .opb(s1_opb),
        .result(ex_result), .writes(ex_writes)
    );

    assign s2_d = {s1_instr.r.op, s1_instr.r.rd, ex_result};

    stage_reg #(.WIDTH(S2_W)) s2_reg (
        .clk(clk), .rst_n(rst_n), .d(s2_d), .q(s2_q),
        .d_writes(ex_writes), .d_dest(c1.dest), .ctl(c2.stage)
    );

    assign {s2_op, s2_rd, s2_result} = s2_q;
    assign s2_is_out = (s2_op == OP_OUT);   // bubbles carry op 0
    assign res_data  = s2_result;

    hazard_ctl hz_i (
        .clk(clk), .rst_n(rst_n),
        .s0_rs1(s0_i.rs1), .s0_rs2(s0_r.rs2), .s0_uses_rs2(s0_uses_rs2),
        .in_valid(in_valid), .in_ready(in_ready),
        .s2_is_out(s2_is_out), .res_valid(res_valid), .res_ready(res_ready),
        .c0(c0.ctl), .c1(c1.ctl), .c2(c2.ctl)
    );

endmodule

// ==== tb/pipe_core_properties.sv ====
`include "pipe_core_config.svh"

// result port checks, bound onto the core
module pipe_core_properties (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  res_valid,
    input logic                  res_ready,
    input logic [`PC_DATA_W-1:0] res_data
);

    timeunit 1ns;
    timeprecision 100ps;

    //////////////////////////////////////////////////////////////////////
    // result handshake
    //////////////////////////////////////////////////////////////////////

    // a stalled result stays put until taken
    hold_until_taken: assert property (
        @(posedge clk) disable iff (!rst_n)
        (res_valid && !res_ready) |=> (res_valid && $stable(res_data))
    ) else $error("res_valid or res_data changed before res_ready");

    // pipe is empty coming out of reset
    quiet_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !res_valid
    ) else $error("res_valid high in the first cycle after reset");

    // no X on a presented result
    known_data: assert property (
        @(posedge clk) disable iff (!rst_n)
        res_valid |-> !$isunknown(res_data)
    ) else $error("res_data has unknown bits while res_valid is high");

endmodule

bind pipe_core_top pipe_core_properties props_i (
    .clk(clk),
    .rst_n(rst_n),
    .res_valid(res_valid),
    .res_ready(res_ready),
    .res_data(res_data)
);

// ==== tb/pipe_core_tb.sv ====
`include "pipe_core_config.svh"

module pipe_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import pipe_core_pkg::*;

    localparam logic [31:0] SEED    = 32'he7990eaf;
    localparam int          N_INSTR = 14 + 64 + 20 + 60 + 400 + 8;  // sum over all tests
    localparam int          LIMIT   = 4 * N_INSTR + 200;            // cycle budget

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    logic                  in_ready;
    logic [`PC_DATA_W-1:0] in_instr;
    logic                  res_valid;
    logic                  res_ready;
    logic [`PC_DATA_W-1:0] res_data;

    logic [`PC_DATA_W-1:0] model_regs [`PC_NREGS];  // reference register state
    logic [`PC_DATA_W-1:0] exp_q [$];                // OUT values still owed
    logic [31:0]           stim_st = SEED;           // stimulus generator state
    logic [31:0]           bp_st   = SEED;           // back-pressure generator state
    bit                    bp_on;
    string                 test_name = "reset";
    int                    cycles;

    pipe_core_top dut_i (.*);

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] st);
        return st * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int unsigned rnd(input int unsigned n);
        stim_st = lcg_step(stim_st);
        return stim_st[31:16] % n;                    // upper bits, better spread
    endfunction

    // op | rd | rs1 | rs2 | pad
    function automatic logic [15:0] r_word(input int op, input int rd, input int rs1,
                                           input int rs2);
        return {op[3:0], rd[2:0], rs1[2:0], rs2[2:0], 3'b000};
    endfunction

    // op | rd | rs1 | imm6
    function automatic logic [15:0] i_word(input int op, input int rd, input int rs1,
                                           input int imm);
        return {op[3:0], rd[2:0], rs1[2:0], imm[5:0]};
    endfunction

    // reference model, one accepted instruction; returns 1 for OUT
    function automatic bit ref_step(input logic [15:0] w, output logic [15:0] val);
        logic [3:0]  op;
        logic [2:0]  rd;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] imm;
        logic [15:0] r;
        bit          wr;
        op  = w[15:12];
        rd  = w[11:9];
        a   = model_regs[w[8:6]];
        b   = model_regs[w[5:3]];
        imm = {{10{w[5]}}, w[5:0]};                   // sign-extended
        wr  = 1'b1;
        r   = '0;
        val = a;                                      // OUT emits rs1
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_XOR:  r = a ^ b;
            OP_ADDI: r = a + imm;
            default: wr = 1'b0;                       // nop, out, unknown
        endcase
        if (wr && (rd != 3'd0))
            model_regs[rd] = r;                       // r0 stays zero
        return (op == OP_OUT);
    endfunction

    task automatic check_eq(input string name, input logic [15:0] exp,
                            input logic [15:0] act);
        if (act !== exp)
        begin
            $display("** Error [%s] expected %h, actual %h", name, exp, act);
            $display("Result: FAILED");
            $fatal(1, "result mismatch");
        end
    endtask

    // called at a falling edge, returns at the falling edge after transfer
    task automatic send(input logic [15:0] w);
        logic [15:0] v;
        in_valid = 1'b1;
        in_instr = w;
        do
            @(posedge clk);
        while (!in_ready);                            // accepted on this edge
        if (ref_step(w, v))
            exp_q.push_back(v);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // reset for 10 rising edges, then in_ready low for one cycle only
    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (model_regs[i])
            model_regs[i] = '0;
        @(posedge clk);
        check_eq(test_name, 16'd0, {15'd0, in_ready});   // start flag still low
        @(negedge clk);
        check_eq(test_name, 16'd1, {15'd0, in_ready});
    endtask

    // wait out every owed result, then a few cycles for trailing writes
    task automatic drain();
        while (exp_q.size() != 0)
            @(negedge clk);
        idle(4);
    endtask

    //////////////////////////////////////////////////////////////////////
    // clock, back-pressure, compare, timeout
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;                        // 4 ns period
    end

    initial
    begin
        bit use_bp;
        res_ready = 1'b1;
        forever
        begin
            @(posedge clk);
            use_bp = bp_on;                           // latch mode away from the drive edge
            @(negedge clk);
            bp_st = lcg_step(bp_st);
            res_ready = use_bp ? bp_st[30] : 1'b1;    // roughly half stalled
        end
    end

    initial
    begin
        bit extra;
        extra = 1'b0;
        while (!extra)
        begin
            @(posedge clk);
            if (rst_n && res_valid && res_ready)
            begin
                if (exp_q.size() == 0)
                    extra = 1'b1;
                else
                    check_eq(test_name, exp_q.pop_front(), res_data);
            end
        end
        $display("result %h arrived with no OUT pending in %s", res_data, test_name);
        $display("Result: FAILED");
        $fatal(1, "unexpected result");
    end

    initial
    begin
        cycles = 0;
        while (cycles < LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, results stopped arriving in %s",
                 cycles, test_name);
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        logic [15:0] w;
        int unsigned g;
        in_valid = 1'b0;
        in_instr = '0;
        bp_on    = 1'b0;
        apply_reset();

        test_name = "alu_ops";                        // operands built from r0
        send(i_word(OP_ADDI, 1, 0, -5));
        send(i_word(OP_ADDI, 2, 0, 27));
        send(i_word(OP_ADDI, 3, 0, -32));
        send(r_word(OP_ADD, 4, 1, 2));
        send(r_word(OP_SUB, 5, 1, 2));
        send(r_word(OP_AND, 6, 1, 3));
        send(r_word(OP_XOR, 7, 2, 3));
        for (int r = 1; r < 8; r++)
            send(r_word(OP_OUT, 0, r, 0));
        drain();

        test_name = "dep_chain";                      // every op reads the last rd
        for (int k = 0; k < 16; k++)
        begin
            send(i_word(OP_ADDI, 1, 1, rnd(64)));
            send(r_word(OP_ADD, 2, 1, 2));
            send(r_word(OP_XOR, 3, 2, 1));
            send(r_word(OP_OUT, 0, 3, 0));
        end
        drain();

        test_name = "r0_and_unknown";
        send(i_word(OP_ADDI, 0, 0, 13));
        send(r_word(OP_ADD, 0, 1, 2));
        send(r_word(OP_OUT, 0, 0, 0));
        for (int k = 7; k < 16; k++)
        begin
            w = rnd(65536);
            send({k[3:0], w[11:0]});                  // opcodes 7..15
        end
        for (int r = 0; r < 8; r++)
            send(r_word(OP_OUT, 0, r, 0));
        drain();

        test_name = "back_pressure";
        bp_on = 1'b1;
        for (int k = 0; k < 30; k++)
        begin
            w = rnd(65536);
            send({OP_ADDI, w[11:0]});
            w = rnd(65536);
            send({OP_OUT, w[11:0]});                  // random rd, rs2 ignored
        end
        drain();
        bp_on = 1'b0;

        test_name = "random_mix";
        for (int k = 0; k < 400; k++)
        begin
            g = rnd(16);
            idle((g < 12) ? 0 : g - 11);              // occasional gap of 1..4
            w = rnd(65536);
            send({1'b0, w[14:0]});                    // ops 0..7
        end
        drain();

        test_name = "mid_reset";
        apply_reset();
        for (int r = 0; r < 8; r++)
            send(r_word(OP_OUT, 0, r, 0));
        drain();

        if (exp_q.size() == 0)
        begin
            $display("Result: PASSED");
            $finish;
        end
        else
        begin
            $display("%0d expected results never arrived", exp_q.size());
            $display("Result: FAILED");
            $fatal(1, "missing results");
        end
    end

endmodule

// ==== pipe_core.f ====
+incdir+hw
hw/pipe_core_pkg.sv
hw/pipe_ctl_if.sv
hw/stage_reg.sv
hw/reg_file.sv
hw/hazard_ctl.sv
hw/exec_unit.sv
hw/pipe_core_top.sv
tb/pipe_core_properties.sv
tb/pipe_core_tb.sv
